// ==== hw/src_defs.svh ====
`ifndef SRC_DEFS_SVH
`define SRC_DEFS_SVH

////////////////////
// datapath widths
////////////////////
`define SRC_SAMPLE_W 24     // one audio channel
`define SRC_COUNT_W  11     // period, phase and divider
`define SRC_SUM_W    36     // two 35 bit products summed

`define SRC_DIV_MIN  11'd7   // keeps ticks at least 8 cycles apart
`define SRC_DIV_RST  11'd511 // 512 clocks per output sample

////////////////////
// axi4-lite register map
////////////////////
`define SRC_AXIL_ADDR_W 12
`define SRC_AXIL_DATA_W 32

`define SRC_REG_CTRL   12'h000
`define SRC_REG_DIV    12'h004
`define SRC_REG_STATUS 12'h008

`endif

// ==== hw/src_cfg_pkg.sv ====
`include "src_defs.svh"

package src_cfg_pkg;

    // register block to tracker
    typedef struct packed {
        logic                    run;
        logic [`SRC_COUNT_W-1:0] div;    // tick every div + 1 clocks
    } src_cfg_t;

    // live status, read back through STATUS
    typedef struct packed {
        logic [`SRC_COUNT_W-1:0] period;
        logic                    overflow; // sticky
        logic [2:0]              level;    // fifo fill, 0 to 4
    } src_status_t;

    // axi4-lite, master to slave
    typedef struct packed {
        logic [`SRC_AXIL_ADDR_W-1:0]   aw_addr;
        logic                          aw_valid;
        logic [`SRC_AXIL_DATA_W-1:0]   w_data;
        logic [`SRC_AXIL_DATA_W/8-1:0] w_strb;
        logic                          w_valid;
        logic                          b_ready;
        logic [`SRC_AXIL_ADDR_W-1:0]   ar_addr;
        logic                          ar_valid;
        logic                          r_ready;
    } axil_req_t;

    // axi4-lite, slave to master
    typedef struct packed {
        logic                        aw_ready;
        logic                        w_ready;
        logic                        b_valid;
        logic [1:0]                  b_resp;
        logic                        ar_ready;
        logic                        r_valid;
        logic [1:0]                  r_resp;
        logic [`SRC_AXIL_DATA_W-1:0] r_data;
    } axil_rsp_t;

endpackage

// ==== hw/src_audio_pkg.sv ====
`include "src_defs.svh"

package src_audio_pkg;

    // one strobe carries both channels
    typedef struct packed {
        logic signed [`SRC_SAMPLE_W-1:0] left;
        logic signed [`SRC_SAMPLE_W-1:0] right;
    } stereo_t;

    ////////////////////
    // tracker to interpolator
    ////////////////////
    typedef struct packed {
        stereo_t                 s0;     // newest input pair
        stereo_t                 s1;     // the one before
        logic [`SRC_COUNT_W-1:0] period; // clocks between strobes
        logic [`SRC_COUNT_W-1:0] phase;  // clocks since s0, not clamped
    } snapshot_t;

    ////////////////////
    // interpolator result
    ////////////////////
    // sums are s1*(period-phase) + s0*phase, left unnormalized
    typedef struct packed {
        logic signed [`SRC_SUM_W-1:0] left;
        logic signed [`SRC_SUM_W-1:0] right;
        logic [`SRC_COUNT_W-1:0]      period; // divisor for a later stage
        logic [`SRC_COUNT_W-1:0]      phase;  // clamped to period
    } result_t;

endpackage

// ==== hw/src_regs.sv ====
`timescale 1ns/1ps
`include "src_defs.svh"

module src_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  src_cfg_pkg::axil_req_t   axil_req,
    output src_cfg_pkg::axil_rsp_t   axil_rsp,
    output src_cfg_pkg::src_cfg_t    cfg,
    input  src_cfg_pkg::src_status_t status,
    output logic                     ovf_clear
);

    logic                        b_valid;
    logic                        r_valid;
    logic [`SRC_AXIL_DATA_W-1:0] r_data;
    logic                        wr_fire;    // aw and w together
    logic                        rd_fire;
    logic [`SRC_COUNT_W-1:0]     div_wr;     // divider after byte lanes
    logic [`SRC_AXIL_DATA_W-1:0] rd_mux;

    // one outstanding response per channel, ready drops while it waits
    assign wr_fire = axil_req.aw_valid && axil_req.w_valid && !b_valid;
    assign rd_fire = axil_req.ar_valid && !r_valid;

    always_comb begin
        axil_rsp.aw_ready = !b_valid;
        axil_rsp.w_ready  = !b_valid;
        axil_rsp.b_valid  = b_valid;
        axil_rsp.b_resp   = 2'b00;   // always OKAY
        axil_rsp.ar_ready = !r_valid;
        axil_rsp.r_valid  = r_valid;
        axil_rsp.r_resp   = 2'b00;
        axil_rsp.r_data   = r_data;
    end

    ////////////////////
    // write path
    ////////////////////
    // low byte in lane 0, bits 10:8 in lane 1
    assign div_wr = {axil_req.w_strb[1] ? axil_req.w_data[10:8] : cfg.div[10:8],
                     axil_req.w_strb[0] ? axil_req.w_data[7:0]  : cfg.div[7:0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.run   <= 1'b0;
            cfg.div   <= `SRC_DIV_RST;
            ovf_clear <= 1'b0;
        end else begin
            ovf_clear <= 1'b0;                  // pulse only
            if (wr_fire) begin
                case (axil_req.aw_addr)
                    `SRC_REG_CTRL: begin
                        if (axil_req.w_strb[0]) begin
                            cfg.run   <= axil_req.w_data[0];
                            ovf_clear <= axil_req.w_data[1];  // self clearing
                        end
                    end
                    `SRC_REG_DIV: begin
                        if (div_wr < `SRC_DIV_MIN)
                            cfg.div <= `SRC_DIV_MIN;  // too fast for the interpolator
                        else
                            cfg.div <= div_wr;
                    end
                    default: ;                         // ignored, still OKAY
                endcase
            end
        end
    end

    // write response
    always_ff @(posedge clk) begin
        if (rst) begin
            b_valid <= 1'b0;
        end else if (wr_fire) begin
            b_valid <= 1'b1;
        end else if (axil_req.b_ready) begin
            b_valid <= 1'b0;
        end
    end

    ////////////////////
    // read path
    ////////////////////
    always_comb begin
        case (axil_req.ar_addr)
            `SRC_REG_CTRL:   rd_mux = {31'b0, cfg.run};     // clear bit reads 0
            `SRC_REG_DIV:    rd_mux = {21'b0, cfg.div};
            `SRC_REG_STATUS: rd_mux = {12'b0, status.level, status.overflow,
                                       5'b0, status.period};
            default:         rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid <= 1'b0;
        end else if (rd_fire) begin
            r_valid <= 1'b1;
        end else if (axil_req.r_ready) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire)
            r_data <= rd_mux;    // held until r_ready
    end

endmodule

// ==== hw/src_rate_tracker.sv ====
`timescale 1ns/1ps
`include "src_defs.svh"

module src_rate_tracker (
    input  logic                      clk,
    input  logic                      rst,
    input  src_cfg_pkg::src_cfg_t     cfg,
    input  logic                      din_en,
    input  src_audio_pkg::stereo_t    din,
    output logic                      tick,
    output src_audio_pkg::snapshot_t  snap,
    output logic [`SRC_COUNT_W-1:0]   period
);

    logic [`SRC_COUNT_W-1:0] cnt;       // clocks since last strobe
    logic [`SRC_COUNT_W-1:0] div_cnt;   // output rate divider
    src_audio_pkg::stereo_t  s0;
    src_audio_pkg::stereo_t  s1;

    ////////////////////
    // input side
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt    <= '0;
            period <= '0;
            s0     <= '0;
            s1     <= '0;
        end else if (din_en) begin
            cnt    <= '0;
            // counter value + 1 is the strobe spacing
            period <= (&cnt) ? cnt : cnt + 11'd1;
            s1     <= s0;
            s0     <= din;
        end else if (!(&cnt)) begin
            cnt <= cnt + 11'd1;             // stops at 2047
        end
    end

    ////////////////////
    // output tick
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (!cfg.run) begin
            div_cnt <= '0;                  // held while stopped
            tick    <= 1'b0;
        end else if (div_cnt >= cfg.div) begin  // >= copes with a lowered divider
            div_cnt <= '0;
            tick    <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 11'd1;
            tick    <= 1'b0;
        end
    end

    // snapshot loads with the tick, all fields from the same cycle
    always_ff @(posedge clk) begin
        if (cfg.run && div_cnt >= cfg.div) begin
            snap.s0     <= s0;
            snap.s1     <= s1;
            snap.period <= period;
            snap.phase  <= cnt;             // raw, interpolator clamps
        end
    end

endmodule

// ==== hw/src_interpolator.sv ====
`timescale 1ns/1ps
`include "src_defs.svh"

module src_interpolator (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     tick,
    input  src_audio_pkg::snapshot_t snap,
    output logic                     push,
    output src_audio_pkg::result_t   res
);

    typedef enum logic [2:0] {
        IDLE,
        COEF,
        MUL0,
        MUL1,
        SUM,
        DONE
    } state_t;

    state_t                          state;
    src_audio_pkg::snapshot_t        held;      // copy taken at the tick
    logic [`SRC_COUNT_W-1:0]         phase_c;   // clamped phase
    logic [`SRC_COUNT_W-1:0]         comp;      // period - phase_c
    logic [`SRC_COUNT_W-1:0]         phase_lim;

    // one time-shared multiplier per channel
    logic signed [`SRC_SAMPLE_W-1:0] mul_l_a;
    logic signed [`SRC_SAMPLE_W-1:0] mul_r_a;
    logic [`SRC_COUNT_W-1:0]         mul_w;
    logic signed [`SRC_SUM_W-1:0]    mul_l_x;   // operands at product width
    logic signed [`SRC_SUM_W-1:0]    mul_r_x;
    logic signed [`SRC_SUM_W-1:0]    mul_w_x;
    logic signed [`SRC_SUM_W-1:0]    mul_l_p;
    logic signed [`SRC_SUM_W-1:0]    mul_r_p;
    logic signed [`SRC_SUM_W-1:0]    prod0_l;   // s0 * phase
    logic signed [`SRC_SUM_W-1:0]    prod0_r;
    logic signed [`SRC_SUM_W-1:0]    prod1_l;   // s1 * complement
    logic signed [`SRC_SUM_W-1:0]    prod1_r;

    // phase runs past the period once strobes stop
    assign phase_lim = (held.phase > held.period) ? held.period : held.phase;

    ////////////////////
    // multipliers
    ////////////////////
    always_comb begin
        if (state == MUL1) begin
            mul_l_a = held.s1.left;
            mul_r_a = held.s1.right;
            mul_w   = comp;
        end else begin
            mul_l_a = held.s0.left;
            mul_r_a = held.s0.right;
            mul_w   = phase_c;
        end
    end

    assign mul_l_x = {{(`SRC_SUM_W-`SRC_SAMPLE_W){mul_l_a[`SRC_SAMPLE_W-1]}}, mul_l_a};
    assign mul_r_x = {{(`SRC_SUM_W-`SRC_SAMPLE_W){mul_r_a[`SRC_SAMPLE_W-1]}}, mul_r_a};
    assign mul_w_x = {{(`SRC_SUM_W-`SRC_COUNT_W){1'b0}}, mul_w};  // zero msbs keep it positive

    assign mul_l_p = mul_l_x * mul_w_x;
    assign mul_r_p = mul_r_x * mul_w_x;

    ////////////////////
    // sequencer
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            push  <= 1'b0;
        end else begin
            push <= 1'b0;
            case (state)
                IDLE:    if (tick) state <= COEF;   // ticks elsewhere are dropped
                COEF:    state <= MUL0;
                MUL0:    state <= MUL1;
                MUL1:    state <= SUM;
                SUM: begin
                    state <= DONE;
                    push  <= 1'b1;                  // high in DONE five cycles after the tick
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // datapath registers stepped by the state
    always_ff @(posedge clk) begin
        if (state == IDLE && tick)
            held <= snap;
        if (state == COEF) begin
            phase_c <= phase_lim;
            comp    <= held.period - phase_lim;     // never negative after clamp
        end
        if (state == MUL0) begin
            prod0_l <= mul_l_p;
            prod0_r <= mul_r_p;
        end
        if (state == MUL1) begin
            prod1_l <= mul_l_p;
            prod1_r <= mul_r_p;
        end
        if (state == SUM) begin
            res.left   <= prod0_l + prod1_l;        // fits in 36 bits
            res.right  <= prod0_r + prod1_r;
            res.period <= held.period;
            res.phase  <= phase_c;
        end
    end

endmodule

// ==== hw/src_out_fifo.sv ====
`timescale 1ns/1ps

module src_out_fifo (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   push,
    input  src_audio_pkg::result_t din,
    output logic                   dout_valid,
    input  logic                   dout_ready,
    output src_audio_pkg::result_t dout,
    output logic [2:0]             level,
    output logic                   overflow,
    input  logic                   ovf_clear
);

    src_audio_pkg::result_t mem [4];
    logic [1:0]             wr_ptr;
    logic [1:0]             rd_ptr;
    logic                   full;
    logic                   wr_en;
    logic                   rd_en;

    assign full       = (level == 3'd4);
    assign wr_en      = push && !full;        // results never wait, dropped if full
    assign dout_valid = (level != 3'd0);
    assign rd_en      = dout_valid && dout_ready;
    assign dout       = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= din;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            level    <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 2'd1;  // wraps at 4
            if (rd_en)
                rd_ptr <= rd_ptr + 2'd1;
            level <= level + {2'b0, wr_en} - {2'b0, rd_en};
            if (push && full)
                overflow <= 1'b1;         // a new drop wins over clear
            else if (ovf_clear)
                overflow <= 1'b0;
        end
    end

endmodule

// ==== hw/src_top.sv ====
`timescale 1ns/1ps
`include "src_defs.svh"

module src_top (
    input  logic                   clk,
    input  logic                   rst,
    input  src_cfg_pkg::axil_req_t axil_req,
    output src_cfg_pkg::axil_rsp_t axil_rsp,
    input  logic                   din_en,
    input  src_audio_pkg::stereo_t din,
    output logic                   dout_valid,
    input  logic                   dout_ready,
    output src_audio_pkg::result_t dout
);

    src_cfg_pkg::src_cfg_t     cfg;
    src_cfg_pkg::src_status_t  status;
    logic                      ovf_clear;
    logic [`SRC_COUNT_W-1:0]   period;    // measured input spacing
    logic                      tick;
    src_audio_pkg::snapshot_t  snap;
    logic                      push;
    src_audio_pkg::result_t    res;
    logic [2:0]                level;
    logic                      overflow;

    assign status = '{period: period, overflow: overflow, level: level};

    ////////////////////
    // control
    ////////////////////
    src_regs i_regs (
        .clk       (clk),
        .rst       (rst),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .cfg       (cfg),
        .status    (status),
        .ovf_clear (ovf_clear)
    );

    ////////////////////
    // datapath
    ////////////////////
    src_rate_tracker i_tracker (
        .clk    (clk),
        .rst    (rst),
        .cfg    (cfg),
        .din_en (din_en),
        .din    (din),
        .tick   (tick),
        .snap   (snap),
        .period (period)
    );

    src_interpolator i_interp (
        .clk  (clk),
        .rst  (rst),
        .tick (tick),
        .snap (snap),
        .push (push),
        .res  (res)
    );

    src_out_fifo i_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .din        (res),
        .dout_valid (dout_valid),
        .dout_ready (dout_ready),
        .dout       (dout),
        .level      (level),
        .overflow   (overflow),
        .ovf_clear  (ovf_clear)
    );

endmodule

// ==== verif/src_assertions.sv ====
`timescale 1ns/1ps

module src_assertions (
    input logic                   clk,
    input logic                   rst,
    input src_cfg_pkg::axil_req_t axil_req,
    input src_cfg_pkg::axil_rsp_t axil_rsp,
    input logic                   dout_valid,
    input logic                   dout_ready,
    input src_audio_pkg::result_t dout
);

    // failure counts, read by the testbench at the end
    int unsigned stable_fails = 0;
    int unsigned b_hold_fails = 0;
    int unsigned r_hold_fails = 0;
    int unsigned phase_fails  = 0;

    ////////////////////
    // output stream
    ////////////////////
    stream_stable: assert property (@(posedge clk) disable iff (rst)
        dout_valid && !dout_ready |=> dout_valid && $stable(dout))
        else begin
            $error("dout changed or dropped while the sink stalled");
            stable_fails++;
        end

    // a result phase is always clamped
    phase_in_range: assert property (@(posedge clk) disable iff (rst)
        dout_valid |-> dout.phase <= dout.period)
        else begin
            $error("result phase above result period");
            phase_fails++;
        end

    ////////////////////
    // axi responses hold until taken
    ////////////////////
    b_hold: assert property (@(posedge clk) disable iff (rst)
        axil_rsp.b_valid && !axil_req.b_ready |=> axil_rsp.b_valid)
        else begin
            $error("b valid dropped before b ready");
            b_hold_fails++;
        end

    r_hold: assert property (@(posedge clk) disable iff (rst)
        axil_rsp.r_valid && !axil_req.r_ready |=> axil_rsp.r_valid)
        else begin
            $error("r valid dropped before r ready");
            r_hold_fails++;
        end

endmodule

bind src_top src_assertions i_assertions (
    .clk        (clk),
    .rst        (rst),
    .axil_req   (axil_req),
    .axil_rsp   (axil_rsp),
    .dout_valid (dout_valid),
    .dout_ready (dout_ready),
    .dout       (dout)
);

// ==== verif/src_tb.sv ====
`timescale 1ns/1ps
`include "src_defs.svh"

module src_tb;

    localparam int WAIT_LIMIT = 500;   // cycles per handshake wait

    logic                   clk;
    logic                   rst;
    src_cfg_pkg::axil_req_t axil_req;
    src_cfg_pkg::axil_rsp_t axil_rsp;
    logic                   din_en;
    src_audio_pkg::stereo_t din;
    logic                   dout_valid;
    logic                   dout_ready;
    src_audio_pkg::result_t dout;

    integer                 seed = 32'hcc77_67ed;
    int                     cycle = 0;
    int                     last_strobe = 0;    // cycle of the latest strobe
    int                     strobe_count = 0;
    src_audio_pkg::stereo_t hist [3];           // 0 is newest sent

    src_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .din_en     (din_en),
        .din        (din),
        .dout_valid (dout_valid),
        .dout_ready (dout_ready),
        .dout       (dout)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////
    // reporting
    ////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp)
            abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic compare_result(input string name, input src_audio_pkg::result_t exp,
                                  input src_audio_pkg::result_t act);
        if (act !== exp)
            abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    endtask

    function automatic int unsigned assert_fails();
        return i_dut.i_assertions.stable_fails + i_dut.i_assertions.b_hold_fails
             + i_dut.i_assertions.r_hold_fails + i_dut.i_assertions.phase_fails;
    endfunction

    ////////////////////
    // bus and stream drivers
    ////////////////////
    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data);
        int n;
        n = 0;
        @(posedge clk);
        axil_req.aw_addr  <= addr;
        axil_req.aw_valid <= 1'b1;
        axil_req.w_data   <= data;
        axil_req.w_strb   <= 4'hf;
        axil_req.w_valid  <= 1'b1;
        axil_req.b_ready  <= 1'b1;
        @(posedge clk);
        while (!(axil_rsp.aw_ready && axil_rsp.w_ready)) begin
            if (n == WAIT_LIMIT) abort_run("write address/data never accepted");
            n++;
            @(posedge clk);
        end
        axil_req.aw_valid <= 1'b0;
        axil_req.w_valid  <= 1'b0;
        n = 0;
        @(posedge clk);
        while (!axil_rsp.b_valid) begin
            if (n == WAIT_LIMIT) abort_run("write response never arrived");
            n++;
            @(posedge clk);
        end
        compare_word("axil_write_resp", 32'd0, {30'b0, axil_rsp.b_resp});  // OKAY
        axil_req.b_ready <= 1'b0;
    endtask

    task automatic axil_read(input logic [11:0] addr, output logic [31:0] data);
        int n;
        n = 0;
        @(posedge clk);
        axil_req.ar_addr  <= addr;
        axil_req.ar_valid <= 1'b1;
        axil_req.r_ready  <= 1'b1;
        @(posedge clk);
        while (!axil_rsp.ar_ready) begin
            if (n == WAIT_LIMIT) abort_run("read address never accepted");
            n++;
            @(posedge clk);
        end
        axil_req.ar_valid <= 1'b0;
        n = 0;
        @(posedge clk);
        while (!axil_rsp.r_valid) begin
            if (n == WAIT_LIMIT) abort_run("read data never arrived");
            n++;
            @(posedge clk);
        end
        data = axil_rsp.r_data;
        compare_word("axil_read_resp", 32'd0, {30'b0, axil_rsp.r_resp});
        axil_req.r_ready <= 1'b0;
    endtask

    function automatic src_audio_pkg::stereo_t random_sample();
        logic [31:0]            rnd;
        src_audio_pkg::stereo_t v;
        rnd     = $random(seed);
        v.left  = rnd[23:0];
        rnd     = $random(seed);
        v.right = rnd[23:0];
        return v;
    endfunction

    // one cycle strobe sampled by the dut on the next edge
    task automatic send_sample(input src_audio_pkg::stereo_t v);
        @(posedge clk);
        din_en      <= 1'b1;
        din         <= v;
        hist[2]     = hist[1];
        hist[1]     = hist[0];
        hist[0]     = v;
        last_strobe = cycle;
        strobe_count++;
        @(posedge clk);
        din_en <= 1'b0;
    endtask

    task automatic strobe_train(input int count, input int spacing);
        int i;
        for (i = 0; i < count; i++) begin
            send_sample(random_sample());
            repeat (spacing - 2) @(posedge clk);    // strobe to strobe = spacing
        end
    endtask

    task automatic wait_strobes(input int target);
        int n;
        n = 0;
        @(posedge clk);
        while (strobe_count < target) begin
            if (n == 10 * WAIT_LIMIT) abort_run("strobe train stalled");
            n++;
            @(posedge clk);
        end
    endtask

    task automatic get_result(output src_audio_pkg::result_t r);
        int n;
        n = 0;
        @(posedge clk);
        while (!(dout_valid && dout_ready)) begin
            if (n == WAIT_LIMIT) abort_run("no result on the output stream");
            n++;
            @(posedge clk);
        end
        r = dout;
    endtask

    ////////////////////
    // expected values
    ////////////////////
    // s1*(period-phase) + s0*phase per channel
    function automatic src_audio_pkg::result_t build_result(
        input src_audio_pkg::stereo_t s0, input src_audio_pkg::stereo_t s1,
        input logic [10:0] period, input logic [10:0] phase);
        logic signed [35:0]     w0;
        logic signed [35:0]     w1;
        logic signed [35:0]     a0;
        logic signed [35:0]     a1;
        src_audio_pkg::result_t r;
        w0       = {25'b0, phase};
        w1       = {25'b0, period - phase};
        a0       = {{12{s0.left[23]}}, s0.left};
        a1       = {{12{s1.left[23]}}, s1.left};
        r.left   = a1 * w1 + a0 * w0;
        a0       = {{12{s0.right[23]}}, s0.right};
        a1       = {{12{s1.right[23]}}, s1.right};
        r.right  = a1 * w1 + a0 * w0;
        r.period = period;
        r.phase  = phase;
        return r;
    endfunction

    task automatic check_result(input string name, input src_audio_pkg::result_t act,
                                input logic [10:0] exp_period);
        src_audio_pkg::stereo_t s0;
        src_audio_pkg::stereo_t s1;
        logic [10:0]            exp_phase;
        int                     since;
        since = cycle - last_strobe;
        // snapshot predates a strobe just sent when its phase is late
        if (since < 12 && act.phase >= 11'd20) begin
            s0 = hist[1];
            s1 = hist[2];
        end else begin
            s0 = hist[0];
            s1 = hist[1];
        end
        if (act.phase > exp_period)
            abort_run($sformatf("ERROR %s: expected phase at most %0d, actual %0d",
                                name, exp_period, act.phase));
        // raw phase is past the period long after the last strobe
        exp_phase = (since > int'(exp_period) + 12) ? exp_period : act.phase;
        compare_result(name, build_result(s0, s1, exp_period, exp_phase), act);
    endtask

    ////////////////////
    // directed tests
    ////////////////////
    task automatic test_regs();
        logic [31:0] rd;
        axil_read(`SRC_REG_CTRL, rd);
        compare_word("regs_ctrl_reset", 32'd0, rd);
        axil_read(`SRC_REG_DIV, rd);
        compare_word("regs_div_reset", 32'd511, rd);
        axil_read(`SRC_REG_STATUS, rd);
        compare_word("regs_status_reset", 32'd0, rd);
        axil_write(`SRC_REG_DIV, 32'd3);            // below minimum
        axil_read(`SRC_REG_DIV, rd);
        compare_word("regs_div_min", 32'd7, rd);
        axil_write(`SRC_REG_DIV, 32'd100);
        axil_read(`SRC_REG_DIV, rd);
        compare_word("regs_div_100", 32'd100, rd);
    endtask

    task automatic test_period();
        logic [31:0] rd;
        strobe_train(3, 20);
        axil_read(`SRC_REG_STATUS, rd);
        compare_word("period_20", 32'd20, rd);
        strobe_train(3, 37);
        axil_read(`SRC_REG_STATUS, rd);
        compare_word("period_37", 32'd37, rd);
    endtask

    task automatic check_stream(input int base);
        src_audio_pkg::result_t r;
        wait_strobes(base + 2);                     // period settled at 40
        axil_write(`SRC_REG_CTRL, 32'd1);
        repeat (20) begin
            get_result(r);
            check_result("interp", r, 11'd40);
        end
    endtask

    task automatic test_interp();
        int base;
        axil_write(`SRC_REG_DIV, 32'd10);
        base = strobe_count;
        fork
            strobe_train(10, 40);
            check_stream(base);
        join
    endtask

    task automatic test_clamp();
        src_audio_pkg::result_t r;
        int                     clamped;
        clamped = 0;
        axil_write(`SRC_REG_CTRL, 32'd0);
        repeat (20) @(posedge clk);                 // let in-flight results drain
        strobe_train(3, 30);
        axil_write(`SRC_REG_CTRL, 32'd1);
        repeat (10) begin
            get_result(r);
            check_result("clamp", r, 11'd30);
            if (r.phase == 11'd30)
                clamped++;
        end
        if (clamped == 0)
            abort_run("no result showed the phase clamped to the period");
    endtask

    task automatic test_backpressure();
        src_audio_pkg::result_t r;
        logic [31:0]            rd;
        int                     n;
        n = 0;
        @(posedge clk);
        dout_ready <= 1'b0;
        axil_read(`SRC_REG_STATUS, rd);
        while (!rd[16]) begin                       // poll for overflow
            if (n == 100) abort_run("overflow never set with the sink stalled");
            n++;
            axil_read(`SRC_REG_STATUS, rd);
        end
        compare_word("backpressure_full", {12'b0, 3'd4, 1'b1, 5'b0, 11'd30}, rd);
        axil_write(`SRC_REG_CTRL, 32'd0);
        repeat (10) @(posedge clk);
        dout_ready <= 1'b1;
        repeat (4) begin
            get_result(r);
            check_result("backpressure_drain", r, 11'd30);
        end
        axil_read(`SRC_REG_STATUS, rd);
        compare_word("backpressure_empty", {12'b0, 3'd0, 1'b1, 5'b0, 11'd30}, rd);
        axil_write(`SRC_REG_CTRL, 32'd2);           // clear overflow with run off
        axil_read(`SRC_REG_STATUS, rd);
        compare_word("backpressure_clear", 32'd30, rd);
    endtask

    task automatic test_stop();
        int n;
        for (n = 0; n < 2000; n++) begin
            @(posedge clk);
            if (dout_valid)
                abort_run("result on the output stream after run was cleared");
        end
    endtask

    initial begin
        rst        <= 1'b1;
        axil_req   <= '0;
        din_en     <= 1'b0;
        din        <= '0;
        dout_ready <= 1'b0;
        hist[0]    = '0;
        hist[1]    = '0;
        hist[2]    = '0;
        repeat (3) @(posedge clk);
        rst        <= 1'b0;
        dout_ready <= 1'b1;
        test_regs();
        test_period();
        test_interp();
        test_clamp();
        test_backpressure();
        test_stop();
        if (assert_fails() == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("assertion failures: %0d", assert_fails());
            $display("Simulation failed");
            $fatal(1, "assertion failures seen");
        end
    end

endmodule

// ==== all.f ====
+incdir+hw
hw/src_cfg_pkg.sv
hw/src_audio_pkg.sv
hw/src_regs.sv
hw/src_rate_tracker.sv
hw/src_interpolator.sv
hw/src_out_fifo.sv
hw/src_top.sv
verif/src_assertions.sv
verif/src_tb.sv

// ==== Makefile ====
# Verilator build and run of the rate converter testbench

VERILATOR ?= verilator
TOP       ?= src_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
